/* common/ooo_pkg.sv */
package ooo_pkg;

  // datapath width for operands and results
  localparam int unsigned data_w = 32;

  // reorder buffer tag, 16 tags in flight
  localparam int unsigned tag_w = 4;

  // station size and the index width that addresses it
  localparam int unsigned rs_depth = 8;
  localparam int unsigned rs_idx_w = 3;

  // alu operations
  // mov passes operand 2 through unchanged
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_orr = 3'd3,
    op_eor = 3'd4,
    op_mov = 3'd5
  } alu_op_t;

  // payload from station select into the issue stage and alu
  // both operand values are resolved by the time this is built
  typedef struct packed {
    alu_op_t             op;
    logic                set_nzcv;
    logic [tag_w-1:0]    dst_tag;
    logic [data_w-1:0]   op1_value;
    logic [data_w-1:0]   op2_value;
  } issue_pkt_t;

  // payload from the alu into the result stage
  // nzcv is ordered n, z, c, v from msb down
  typedef struct packed {
    logic [tag_w-1:0]    dst_tag;
    logic [data_w-1:0]   value;
    logic [3:0]          nzcv;
    logic                nzcv_valid;
  } result_pkt_t;

endpackage

/* hw/pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     in_clk,
  input  logic     in_rst,
  input  logic     flush,
  // upstream side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  // downstream side
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // accept when empty or when the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;

  // occupancy flag
  // a flush drops whatever is held, same as reset
  always_ff @(posedge in_clk) begin
    if (in_rst || flush) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // payload only moves on an accepted transfer
  // held stable under back-pressure
  always_ff @(posedge in_clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

/* reservation_station/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
  input  logic                           in_clk,
  input  logic                           in_rst,
  input  logic                           flush,
  // dispatch
  input  logic                           dispatch_valid,
  output logic                           dispatch_ready,
  input  ooo_pkg::alu_op_t               op,
  input  logic                           set_nzcv,
  input  logic [ooo_pkg::tag_w-1:0]      dst_tag,
  input  logic                           op1_ready,
  input  logic [ooo_pkg::tag_w-1:0]      op1_tag,
  input  logic [ooo_pkg::data_w-1:0]     op1_value,
  input  logic                           op2_ready,
  input  logic [ooo_pkg::tag_w-1:0]      op2_tag,
  input  logic [ooo_pkg::data_w-1:0]     op2_value,
  // rob broadcast for results of other units
  input  logic                           rob_bcast_valid,
  input  logic [ooo_pkg::tag_w-1:0]      rob_bcast_tag,
  input  logic [ooo_pkg::data_w-1:0]     rob_bcast_value,
  // our own alu result bus
  input  logic                           cdb_valid,
  input  logic [ooo_pkg::tag_w-1:0]      cdb_tag,
  input  logic [ooo_pkg::data_w-1:0]     cdb_value,
  // to the issue stage
  output logic                           issue_valid,
  input  logic                           issue_ready,
  output ooo_pkg::issue_pkt_t            issue_pkt
);

  // per-entry control
  logic [ooo_pkg::rs_depth-1:0]   ent_valid;
  logic [ooo_pkg::rs_depth-1:0]   ent_op1_rdy;
  logic [ooo_pkg::rs_depth-1:0]   ent_op2_rdy;

  // per-entry payload
  ooo_pkg::alu_op_t               ent_op       [ooo_pkg::rs_depth];
  logic                           ent_set_nzcv [ooo_pkg::rs_depth];
  logic [ooo_pkg::tag_w-1:0]      ent_dst_tag  [ooo_pkg::rs_depth];
  logic [ooo_pkg::tag_w-1:0]      ent_op1_tag  [ooo_pkg::rs_depth];
  logic [ooo_pkg::tag_w-1:0]      ent_op2_tag  [ooo_pkg::rs_depth];
  logic [ooo_pkg::data_w-1:0]     ent_op1_val  [ooo_pkg::rs_depth];
  logic [ooo_pkg::data_w-1:0]     ent_op2_val  [ooo_pkg::rs_depth];

  // allocation and select
  logic [ooo_pkg::rs_depth-1:0]   free_vec;
  logic [ooo_pkg::rs_depth-1:0]   alloc_oh;
  logic [ooo_pkg::rs_depth-1:0]   ready_vec;
  logic [ooo_pkg::rs_depth-1:0]   sel_oh;
  logic [ooo_pkg::rs_idx_w-1:0]   sel_idx;
  logic                           dispatch_fire;
  logic                           issue_fire;

  // true when either bus is broadcasting this tag
  function automatic logic bus_hit(input logic [ooo_pkg::tag_w-1:0] tag);
    bus_hit = (cdb_valid && (cdb_tag == tag)) ||
              (rob_bcast_valid && (rob_bcast_tag == tag));
  endfunction

  // operand value after wakeup
  // an already known value wins, then our cdb, then the rob broadcast
  function automatic logic [ooo_pkg::data_w-1:0] resolve_val(
    input logic                       rdy,
    input logic [ooo_pkg::tag_w-1:0]  tag,
    input logic [ooo_pkg::data_w-1:0] value
  );
    if (rdy) begin
      resolve_val = value;
    end else if (cdb_valid && (cdb_tag == tag)) begin
      resolve_val = cdb_value;
    end else if (rob_bcast_valid && (rob_bcast_tag == tag)) begin
      resolve_val = rob_bcast_value;
    end else begin
      resolve_val = value;
    end
  endfunction

  // lowest free slot, isolated as the lowest set bit
  assign free_vec       = ~ent_valid;
  assign alloc_oh       = free_vec & (~free_vec + 1'b1);
  assign dispatch_ready = |free_vec;
  assign dispatch_fire  = dispatch_valid && dispatch_ready;

  // lowest ready entry, same trick
  assign ready_vec   = ent_valid & ent_op1_rdy & ent_op2_rdy;
  assign sel_oh      = ready_vec & (~ready_vec + 1'b1);
  assign issue_valid = |ready_vec;
  assign issue_fire  = issue_valid && issue_ready;

  // index of the selected entry for the payload mux
  always_comb begin
    sel_idx = '0;
    for (int i = ooo_pkg::rs_depth - 1; i >= 0; i--) begin
      if (ready_vec[i]) begin
        sel_idx = i[ooo_pkg::rs_idx_w-1:0];
      end
    end
  end

  assign issue_pkt.op        = ent_op[sel_idx];
  assign issue_pkt.set_nzcv  = ent_set_nzcv[sel_idx];
  assign issue_pkt.dst_tag   = ent_dst_tag[sel_idx];
  assign issue_pkt.op1_value = ent_op1_val[sel_idx];
  assign issue_pkt.op2_value = ent_op2_val[sel_idx];

  // occupancy and operand ready bits
  always_ff @(posedge in_clk) begin
    if (in_rst || flush) begin
      ent_valid   <= '0;
      ent_op1_rdy <= '0;
      ent_op2_rdy <= '0;
    end else begin
      for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
        if (dispatch_fire && alloc_oh[i]) begin
          // new entry also snoops both buses this edge
          ent_valid[i]   <= 1'b1;
          ent_op1_rdy[i] <= op1_ready || bus_hit(op1_tag);
          ent_op2_rdy[i] <= op2_ready || bus_hit(op2_tag);
        end else begin
          // tag wakeup on stored entries
          if (ent_valid[i] && !ent_op1_rdy[i] && bus_hit(ent_op1_tag[i])) begin
            ent_op1_rdy[i] <= 1'b1;
          end
          if (ent_valid[i] && !ent_op2_rdy[i] && bus_hit(ent_op2_tag[i])) begin
            ent_op2_rdy[i] <= 1'b1;
          end
          // issued entry frees on the handshake edge
          if (issue_fire && sel_oh[i]) begin
            ent_valid[i] <= 1'b0;
          end
        end
      end
    end
  end

  // entry payload
  always_ff @(posedge in_clk) begin
    for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
      if (dispatch_fire && alloc_oh[i]) begin
        ent_op[i]       <= op;
        ent_set_nzcv[i] <= set_nzcv;
        ent_dst_tag[i]  <= dst_tag;
        ent_op1_tag[i]  <= op1_tag;
        ent_op2_tag[i]  <= op2_tag;
        ent_op1_val[i]  <= resolve_val(op1_ready, op1_tag, op1_value);
        ent_op2_val[i]  <= resolve_val(op2_ready, op2_tag, op2_value);
      end else begin
        // capture the broadcast value on a tag match
        if (!ent_op1_rdy[i] && bus_hit(ent_op1_tag[i])) begin
          ent_op1_val[i] <= resolve_val(1'b0, ent_op1_tag[i], ent_op1_val[i]);
        end
        if (!ent_op2_rdy[i] && bus_hit(ent_op2_tag[i])) begin
          ent_op2_val[i] <= resolve_val(1'b0, ent_op2_tag[i], ent_op2_val[i]);
        end
      end
    end
  end

endmodule

/* hw/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
  input  logic                  in_valid,
  output logic                  in_ready,
  input  ooo_pkg::issue_pkt_t   issue,
  output logic                  out_valid,
  input  logic                  out_ready,
  output ooo_pkg::result_pkt_t  result
);

  // operands and the wide sum used for carry out
  logic [ooo_pkg::data_w-1:0] a;
  logic [ooo_pkg::data_w-1:0] b;
  logic [ooo_pkg::data_w:0]   sum_ext;
  logic [ooo_pkg::data_w-1:0] res;
  logic                       flag_c;
  logic                       flag_v;

  assign a = issue.op1_value;
  assign b = issue.op2_value;

  // single cycle unit, handshake passes straight through
  assign out_valid = in_valid;
  assign in_ready  = out_ready;

  always_comb begin
    sum_ext = '0;
    res     = '0;
    flag_c  = 1'b0;
    flag_v  = 1'b0;
    case (issue.op)
      ooo_pkg::op_add: begin
        sum_ext = {1'b0, a} + {1'b0, b};
        res     = sum_ext[ooo_pkg::data_w-1:0];
        flag_c  = sum_ext[ooo_pkg::data_w];
        // same sign in, different sign out
        flag_v  = (a[ooo_pkg::data_w-1] == b[ooo_pkg::data_w-1]) &&
                  (res[ooo_pkg::data_w-1] != a[ooo_pkg::data_w-1]);
      end
      ooo_pkg::op_sub: begin
        // a + ~b + 1, carry set means no borrow
        sum_ext = {1'b0, a} + {1'b0, ~b} + 1'b1;
        res     = sum_ext[ooo_pkg::data_w-1:0];
        flag_c  = sum_ext[ooo_pkg::data_w];
        flag_v  = (a[ooo_pkg::data_w-1] != b[ooo_pkg::data_w-1]) &&
                  (res[ooo_pkg::data_w-1] != a[ooo_pkg::data_w-1]);
      end
      ooo_pkg::op_and: res = a & b;
      ooo_pkg::op_orr: res = a | b;
      ooo_pkg::op_eor: res = a ^ b;
      ooo_pkg::op_mov: res = b;
      default:         res = '0;
    endcase
  end

  // result payload
  // flags only reported when the instruction asked for them
  assign result.dst_tag    = issue.dst_tag;
  assign result.value      = res;
  assign result.nzcv       = issue.set_nzcv ?
                             {res[ooo_pkg::data_w-1], (res == '0), flag_c, flag_v} : 4'b0000;
  assign result.nzcv_valid = issue.set_nzcv;

endmodule

/* hw/ooo_exec_top.sv */
`timescale 1ns/1ps

module ooo_exec_top (
  input  logic                        in_clk,
  input  logic                        in_rst,
  input  logic                        flush,
  // dispatch
  input  logic                        dispatch_valid,
  output logic                        dispatch_ready,
  input  ooo_pkg::alu_op_t            op,
  input  logic                        set_nzcv,
  input  logic [ooo_pkg::tag_w-1:0]   dst_tag,
  input  logic                        op1_ready,
  input  logic [ooo_pkg::tag_w-1:0]   op1_tag,
  input  logic [ooo_pkg::data_w-1:0]  op1_value,
  input  logic                        op2_ready,
  input  logic [ooo_pkg::tag_w-1:0]   op2_tag,
  input  logic [ooo_pkg::data_w-1:0]  op2_value,
  // rob broadcast strobe
  input  logic                        rob_bcast_valid,
  input  logic [ooo_pkg::tag_w-1:0]   rob_bcast_tag,
  input  logic [ooo_pkg::data_w-1:0]  rob_bcast_value,
  // results
  output logic                        result_valid,
  input  logic                        result_ready,
  output logic [ooo_pkg::tag_w-1:0]   result_tag,
  output logic [ooo_pkg::data_w-1:0]  result_value,
  output logic [3:0]                  result_nzcv,
  output logic                        result_nzcv_valid
);

  // station to issue stage
  logic                        issue_valid;
  logic                        issue_ready;
  ooo_pkg::issue_pkt_t         issue_pkt;
  // issue stage to alu
  logic                        exe_valid;
  logic                        exe_ready;
  ooo_pkg::issue_pkt_t         exe_pkt;
  // alu to result stage
  logic                        alu_valid;
  logic                        alu_ready;
  ooo_pkg::result_pkt_t        alu_result;
  // result stage output
  ooo_pkg::result_pkt_t        res_pkt;
  // common data bus, a result handshake fed back for wakeup
  logic                        cdb_valid;

  assign cdb_valid         = result_valid && result_ready;
  assign result_tag        = res_pkt.dst_tag;
  assign result_value      = res_pkt.value;
  assign result_nzcv       = res_pkt.nzcv;
  assign result_nzcv_valid = res_pkt.nzcv_valid;

  reservation_station u_rs (
    .in_clk, .in_rst, .flush,
    .dispatch_valid, .dispatch_ready,
    .op, .set_nzcv, .dst_tag,
    .op1_ready, .op1_tag, .op1_value,
    .op2_ready, .op2_tag, .op2_value,
    .rob_bcast_valid, .rob_bcast_tag, .rob_bcast_value,
    .cdb_valid, .cdb_tag(res_pkt.dst_tag), .cdb_value(res_pkt.value),
    .issue_valid, .issue_ready, .issue_pkt
  );

  // issue register between select and execute
  pipe_stage #(.payload_t(ooo_pkg::issue_pkt_t)) u_issue_stage (
    .in_clk, .in_rst, .flush,
    .in_valid(issue_valid), .in_ready(issue_ready), .in_data(issue_pkt),
    .out_valid(exe_valid), .out_ready(exe_ready), .out_data(exe_pkt)
  );

  alu_unit u_alu (
    .in_valid(exe_valid), .in_ready(exe_ready), .issue(exe_pkt),
    .out_valid(alu_valid), .out_ready(alu_ready), .result(alu_result)
  );

  // result register, drives the outside port and the cdb
  pipe_stage #(.payload_t(ooo_pkg::result_pkt_t)) u_result_stage (
    .in_clk, .in_rst, .flush,
    .in_valid(alu_valid), .in_ready(alu_ready), .in_data(alu_result),
    .out_valid(result_valid), .out_ready(result_ready), .out_data(res_pkt)
  );

endmodule

/* verification/ooo_exec_sva.sv */
`timescale 1ns/1ps

module ooo_exec_sva (
  input logic                        in_clk,
  input logic                        in_rst,
  input logic                        flush,
  input logic                        dispatch_ready,
  input logic                        result_valid,
  input logic                        result_ready,
  input logic [ooo_pkg::tag_w-1:0]   result_tag,
  input logic [ooo_pkg::data_w-1:0]  result_value,
  input logic [3:0]                  result_nzcv,
  input logic                        result_nzcv_valid
);

  // stalled result keeps its whole payload
  a_result_hold: assert property (@(posedge in_clk) disable iff (in_rst || flush)
    (result_valid && !result_ready) |=>
      (result_valid && $stable(result_tag) && $stable(result_value) &&
       $stable(result_nzcv) && $stable(result_nzcv_valid)))
    else $error("result payload moved while stalled");

  // first cycle out of reset, station empty and no result
  a_after_reset: assert property (@(posedge in_clk)
    ($past(in_rst) && !in_rst) |-> (dispatch_ready && !result_valid))
    else $error("bad state in the cycle after reset");

  // flush empties the result stage
  a_after_flush: assert property (@(posedge in_clk) disable iff (in_rst)
    flush |=> !result_valid)
    else $error("result_valid high in the cycle after flush");

endmodule

bind ooo_exec_top ooo_exec_sva sva0 (
  .in_clk(in_clk),
  .in_rst(in_rst),
  .flush(flush),
  .dispatch_ready(dispatch_ready),
  .result_valid(result_valid),
  .result_ready(result_ready),
  .result_tag(result_tag),
  .result_value(result_value),
  .result_nzcv(result_nzcv),
  .result_nzcv_valid(result_nzcv_valid)
);

/* verification/ooo_exec_tb.sv */
`timescale 1ns/1ps

module ooo_exec_tb;

  localparam int timeout = 200;
  // operand kinds in the table
  localparam int k_lit = 0;
  localparam int k_prod = 1;
  localparam int k_rob = 2;
  localparam int k_rand = 3;

  logic in_clk, in_rst, flush, dispatch_valid, dispatch_ready, set_nzcv;
  ooo_pkg::alu_op_t op;
  logic [ooo_pkg::tag_w-1:0] dst_tag, op1_tag, op2_tag, rob_bcast_tag, result_tag;
  logic [ooo_pkg::data_w-1:0] op1_value, op2_value, rob_bcast_value, result_value;
  logic op1_ready, op2_ready, rob_bcast_valid, result_valid, result_ready;
  logic [3:0] result_nzcv;
  logic result_nzcv_valid;

  // instruction table, one row per instruction
  string tname[6];
  int r_test[40], r_dst[40], r_k1[40], r_k2[40], r_dly[40];
  logic [31:0] r_v1[40], r_v2[40];
  ooo_pkg::alu_op_t r_op[40];
  bit r_nz[40];
  int nrows;

  // reference model and scoreboard, indexed by tag
  logic [31:0] model_val[16], got_val[16];
  logic [3:0] exp_nzcv[16], got_nzcv[16];
  bit exp_nzv[16], got_nzv[16], rob_set[16];
  int got_seen[16], got_order[16];
  int arrival, errors, test_errs, failed_tests, seed, cnt;
  bit rand_ready;
  logic [31:0] hold_val;
  logic [3:0] hold_tag;

  ooo_exec_top dut0 (.*);

  initial begin
    in_clk = 1'b0;
    forever #2 in_clk = ~in_clk;
  end

  // every accepted result is recorded by tag
  always @(posedge in_clk) begin
    if (!in_rst && result_valid && result_ready) begin
      got_seen[result_tag]++;
      got_val[result_tag] = result_value;
      got_nzcv[result_tag] = result_nzcv;
      got_nzv[result_tag] = result_nzcv_valid;
      arrival++;
      got_order[result_tag] = arrival;
    end
  end

  task automatic add_row(input int t, input ooo_pkg::alu_op_t o, input bit nz, input int dst,
                         input int k1, input logic [31:0] v1, input int k2,
                         input logic [31:0] v2, input int dly);
    r_test[nrows] = t;
    r_op[nrows] = o;
    r_nz[nrows] = nz;
    r_dst[nrows] = dst;
    r_k1[nrows] = k1;
    r_v1[nrows] = v1;
    r_k2[nrows] = k2;
    r_v2[nrows] = v2;
    r_dly[nrows] = dly;
    nrows++;
  endtask

  // {nzcv, value} straight from the ALU rules
  function automatic logic [35:0] alu_ref(input ooo_pkg::alu_op_t o, input logic [31:0] a,
                                          input logic [31:0] b, input bit nz);
    logic [32:0] wide;
    logic [31:0] r;
    longint sr;
    bit c;
    bit v;
    c = 1'b0;
    v = 1'b0;
    wide = '0;
    case (o)
      ooo_pkg::op_add: begin
        wide = {1'b0, a} + {1'b0, b};
        r = wide[31:0];
        c = wide[32];
        sr = longint'($signed(a)) + longint'($signed(b));
        v = (sr > 64'sd2147483647) || (sr < -64'sd2147483648);
      end
      ooo_pkg::op_sub: begin
        r = a - b;
        // carry means no borrow
        c = (a >= b);
        sr = longint'($signed(a)) - longint'($signed(b));
        v = (sr > 64'sd2147483647) || (sr < -64'sd2147483648);
      end
      ooo_pkg::op_and: r = a & b;
      ooo_pkg::op_orr: r = a | b;
      ooo_pkg::op_eor: r = a ^ b;
      default: r = b;
    endcase
    alu_ref = {nz ? {r[31], (r == 32'd0), c, v} : 4'b0000, r};
  endfunction

  // operand value as the model sees it
  function automatic logic [31:0] operand_val(input int k, input logic [31:0] v);
    if (k == k_rand) return $random(seed);
    if (k == k_lit) return v;
    if (k == k_rob && !rob_set[v[3:0]]) begin
      model_val[v[3:0]] = $random(seed);
      rob_set[v[3:0]] = 1'b1;
    end
    return model_val[v[3:0]];
  endfunction

  task automatic broadcast(input logic [3:0] tag);
    rob_bcast_valid = 1'b1;
    rob_bcast_tag = tag;
    rob_bcast_value = model_val[tag];
    @(negedge in_clk);
    rob_bcast_valid = 1'b0;
  endtask

  // waits for a free slot, then drives one row for a single cycle
  task automatic dispatch_row(input int r);
    logic [31:0] a;
    logic [31:0] b;
    logic [35:0] exp;
    int rob_tag;
    rob_tag = -1;
    a = operand_val(r_k1[r], r_v1[r]);
    b = operand_val(r_k2[r], r_v2[r]);
    if (r_k1[r] == k_rob) rob_tag = int'(r_v1[r]);
    if (r_k2[r] == k_rob) rob_tag = int'(r_v2[r]);
    exp = alu_ref(r_op[r], a, b, r_nz[r]);
    model_val[r_dst[r]] = exp[31:0];
    exp_nzcv[r_dst[r]] = exp[35:32];
    exp_nzv[r_dst[r]] = r_nz[r];
    cnt = 0;
    while (!dispatch_ready && cnt < timeout) begin
      @(negedge in_clk);
      cnt++;
    end
    if (!dispatch_ready) begin
      $display("dispatch_ready never came back for %s", tname[r_test[r]]);
      test_errs++;
    end
    if (r_dly[r] == 0 && rob_tag >= 0) begin
      rob_bcast_valid = 1'b1;
      rob_bcast_tag = rob_tag[3:0];
      rob_bcast_value = model_val[rob_tag];
    end
    dispatch_valid = 1'b1;
    op = r_op[r];
    set_nzcv = r_nz[r];
    dst_tag = r_dst[r][3:0];
    op1_ready = (r_k1[r] == k_lit) || (r_k1[r] == k_rand);
    op1_tag = op1_ready ? 4'd0 : r_v1[r][3:0];
    op1_value = op1_ready ? a : 32'd0;
    op2_ready = (r_k2[r] == k_lit) || (r_k2[r] == k_rand);
    op2_tag = op2_ready ? 4'd0 : r_v2[r][3:0];
    op2_value = op2_ready ? b : 32'd0;
    @(negedge in_clk);
    dispatch_valid = 1'b0;
    rob_bcast_valid = 1'b0;
    if (r_dly[r] > 0) begin
      repeat (r_dly[r]) @(negedge in_clk);
      if (got_seen[r_dst[r]] != 0) begin
        $display("%s: tag %0d issued before its broadcast", tname[r_test[r]], r_dst[r]);
        test_errs++;
      end
      broadcast(rob_tag[3:0]);
    end
  endtask

  initial begin
    seed = 12461;
    in_rst = 1'b1;
    {flush, dispatch_valid, set_nzcv, op1_ready, op2_ready, rob_bcast_valid} = '0;
    op = ooo_pkg::op_add;
    {dst_tag, op1_tag, op2_tag, rob_bcast_tag} = '0;
    {op1_value, op2_value, rob_bcast_value} = '0;
    result_ready = 1'b1;
    {nrows, arrival, errors, failed_tests, rand_ready} = '0;
    tname = '{"indep_ops", "chain", "rob_wait", "nzcv", "full_stall", "flush"};
    for (int i = 0; i < 6; i++) begin
      add_row(0, ooo_pkg::alu_op_t'(i), 1'b0, i + 1, k_rand, 0, k_rand, 0, -1);
    end
    // each link names the tag before it
    add_row(1, ooo_pkg::op_add, 1'b0, 1, k_lit, 5, k_lit, 7, -1);
    add_row(1, ooo_pkg::op_sub, 1'b0, 2, k_prod, 1, k_lit, 2, -1);
    add_row(1, ooo_pkg::op_eor, 1'b0, 3, k_prod, 2, k_lit, 32'h00ff00ff, -1);
    add_row(1, ooo_pkg::op_mov, 1'b0, 4, k_lit, 0, k_prod, 3, -1);
    add_row(2, ooo_pkg::op_add, 1'b0, 7, k_rob, 12, k_rand, 0, 4);
    add_row(2, ooo_pkg::op_sub, 1'b1, 8, k_rand, 0, k_rob, 13, 0);
    // flag corners
    add_row(3, ooo_pkg::op_add, 1'b1, 0, k_lit, 0, k_lit, 0, -1);
    add_row(3, ooo_pkg::op_add, 1'b1, 1, k_lit, 32'h7fffffff, k_lit, 1, -1);
    add_row(3, ooo_pkg::op_add, 1'b1, 2, k_lit, 32'hffffffff, k_lit, 1, -1);
    add_row(3, ooo_pkg::op_sub, 1'b1, 3, k_lit, 5, k_lit, 5, -1);
    add_row(3, ooo_pkg::op_sub, 1'b1, 4, k_lit, 32'h80000000, k_lit, 1, -1);
    add_row(3, ooo_pkg::op_sub, 1'b1, 5, k_lit, 1, k_lit, 2, -1);
    add_row(3, ooo_pkg::op_add, 1'b0, 6, k_lit, 32'h7fffffff, k_lit, 1, -1);
    for (int i = 0; i < 8; i++) begin
      add_row(4, ooo_pkg::alu_op_t'(i % 6), 1'b1, i, k_rob, 15, k_rand, 0, -1);
    end
    // full station on tag 14, either operand waiting
    for (int i = 0; i < 8; i++) begin
      add_row(5, ooo_pkg::alu_op_t'(i % 6), 1'b0, i, (i % 2 == 0) ? k_rob : k_rand, 14,
              (i % 2 == 0) ? k_rand : k_rob, 14, -1);
    end

    repeat (5) @(negedge in_clk);
    in_rst = 1'b0;
    @(negedge in_clk);

    for (int t = 0; t < 6; t++) begin
      test_errs = 0;
      for (int i = 0; i < 16; i++) begin
        got_seen[i] = 0;
        rob_set[i] = 1'b0;
      end
      for (int r = 0; r < nrows; r++) begin
        if (r_test[r] != t) continue;
        dispatch_row(r);
        // lone ready instruction, result two edges after acceptance
        if (r == 0) begin
          @(negedge in_clk);
          if (result_valid) begin
            $display("[ERROR] %s: result_valid expected 0 actual 1 one cycle in", tname[t]);
            test_errs++;
          end
          @(negedge in_clk);
          if (!result_valid) begin
            $display("[ERROR] %s: result_valid expected 1 actual 0 two cycles in", tname[t]);
            test_errs++;
          end
        end
      end
      if (t == 4) begin
        if (dispatch_ready) begin
          $display("[ERROR] %s: dispatch_ready expected 0 actual 1", tname[t]);
          test_errs++;
        end
        result_ready = 1'b0;
        broadcast(4'd15);
        cnt = 0;
        while (!result_valid && cnt < timeout) begin
          @(negedge in_clk);
          cnt++;
        end
        if (!result_valid) begin
          $display("%s: result_valid never rose after the broadcast", tname[t]);
          test_errs++;
        end
        hold_val = result_value;
        hold_tag = result_tag;
        repeat (4) begin
          @(negedge in_clk);
          if (result_value !== hold_val || result_tag !== hold_tag || !result_valid) begin
            $display("[ERROR] %s: held result expected %h actual %h", tname[t], hold_val,
                     result_value);
            test_errs++;
          end
        end
        rand_ready = 1'b1;
      end
      if (t == 5) begin
        if (dispatch_ready) begin
          $display("[ERROR] %s: dispatch_ready before flush expected 0 actual 1", tname[t]);
          test_errs++;
        end
        flush = 1'b1;
        @(negedge in_clk);
        flush = 1'b0;
        if (!dispatch_ready) begin
          $display("[ERROR] %s: dispatch_ready expected 1 actual 0", tname[t]);
          test_errs++;
        end
        broadcast(4'd14);
        repeat (10) @(negedge in_clk);
      end
      for (int r = 0; r < nrows; r++) begin
        if (r_test[r] != t) continue;
        if (t == 5) begin
          if (got_seen[r_dst[r]] != 0) begin
            $display("%s: a result came out for flushed tag %0d", tname[t], r_dst[r]);
            test_errs++;
          end
          continue;
        end
        cnt = 0;
        while (got_seen[r_dst[r]] == 0 && cnt < timeout) begin
          @(negedge in_clk);
          if (rand_ready) result_ready = ($random(seed) & 1) != 0;
          cnt++;
        end
        if (got_seen[r_dst[r]] == 0) begin
          $display("%s: timed out waiting for tag %0d", tname[t], r_dst[r]);
          test_errs++;
        end else begin
          if (got_val[r_dst[r]] !== model_val[r_dst[r]]) begin
            $display("[ERROR] %s: value expected %h actual %h", tname[t],
                     model_val[r_dst[r]], got_val[r_dst[r]]);
            test_errs++;
          end
          if (got_nzcv[r_dst[r]] !== exp_nzcv[r_dst[r]] ||
              got_nzv[r_dst[r]] !== exp_nzv[r_dst[r]]) begin
            $display("[ERROR] %s: nzcv expected %b/%b actual %b/%b", tname[t],
                     exp_nzcv[r_dst[r]], exp_nzv[r_dst[r]], got_nzcv[r_dst[r]],
                     got_nzv[r_dst[r]]);
            test_errs++;
          end
          // a consumer never finishes before its producer
          if (r_k1[r] == k_prod && got_order[r_dst[r]] <= got_order[r_v1[r]]) begin
            $display("%s: tag %0d finished before its producer tag %0d", tname[t],
                     r_dst[r], r_v1[r]);
            test_errs++;
          end
          if (r_k2[r] == k_prod && got_order[r_dst[r]] <= got_order[r_v2[r]]) begin
            $display("%s: tag %0d finished before its producer tag %0d", tname[t],
                     r_dst[r], r_v2[r]);
            test_errs++;
          end
        end
      end
      rand_ready = 1'b0;
      result_ready = 1'b1;
      @(negedge in_clk);
      $display("test %s finished with %0d errors", tname[t], test_errs);
      errors += test_errs;
      if (test_errs != 0) failed_tests++;
    end

    $display("tests run 6, tests failing %0d, errors %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* ooo_exec.f */
common/ooo_pkg.sv
hw/pipe_stage.sv
reservation_station/reservation_station.sv
hw/alu_unit.sv
hw/ooo_exec_top.sv
verification/ooo_exec_sva.sv
verification/ooo_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ooo_exec_tb \
  -f ooo_exec.f \
  -o ooo_exec_sim

out=$(./obj_dir/ooo_exec_sim)
echo "$out"

# pass only when the pass line shows up
echo "$out" | grep -q "^Test passed$" || exit 1
